// File: flist.f
+incdir+tb
design/sa_pkg.sv
design/inst_intake.sv
design/operand_store.sv
design/inst_sequencer.sv
design/skew_loader.sv
design/inst_reader_top.sv
tb/tb_inst_reader.sv

// File: Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_inst_reader
RTL_TOP   ?= inst_reader_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= $(filter design/%,$(shell cat $(FLIST)))

FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Opcode of ST which the DUT treats as a no-op
localparam logic [sa_pkg::OPCODE_W-1:0] OP_ST = 4'd3;

localparam int NUM_INSTS      = 40;
localparam int ACK_LIMIT      = 40;
localparam int TIMEOUT_CYCLES = sa_pkg::STORE_DEPTH + NUM_INSTS * 40 + 200;

logic [31:0]                    rng_state = 32'd82;
logic [sa_pkg::DATA_W-1:0]      image [sa_pkg::STORE_DEPTH];

function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
endfunction

// Row written at step s of an LD from base b as read from the image
function automatic logic [sa_pkg::ROW_W-1:0] skew_row(input logic [sa_pkg::MEM_LOC_W-1:0] base,
                                                      input int step);
        logic [sa_pkg::ROW_W-1:0]       r;
        logic [sa_pkg::MEM_LOC_W-1:0]   addr;
        int                             d;
        r = '0;
        for (int j = 0; j < sa_pkg::ARRAY_DIM; j++)
        begin
                d = step - j;
                if (d >= 0 && d < sa_pkg::ARRAY_DIM)
                begin
                        addr = sa_pkg::MEM_LOC_W'((int'(base) + d * sa_pkg::ARRAY_DIM + j)
                                % sa_pkg::STORE_DEPTH);
                        r[j*sa_pkg::DATA_W +: sa_pkg::DATA_W] = image[addr];
                end
        end
        return r;
endfunction

// Kind 0 to 6 picks LD-left, LD-top, LD id 2, GEMM, DRAINSYS, ST or an unused code
function automatic logic [sa_pkg::INST_W-1:0] make_inst(input int kind, input logic [31:0] r);
        logic [sa_pkg::INST_W-1:0]      w;
        logic [sa_pkg::OPCODE_W-1:0]    op;
        logic [sa_pkg::BUF_ID_W-1:0]    id;
        op = r[15:12];
        id = r[11:10];
        case (kind)
        0:
        begin
                op = sa_pkg::OP_LD;
                id = sa_pkg::BUF_LEFT;
        end
        1:
        begin
                op = sa_pkg::OP_LD;
                id = sa_pkg::BUF_TOP;
        end
        2:
        begin
                op = sa_pkg::OP_LD;
                id = 2'd2;
        end
        3:       op = sa_pkg::OP_GEMM;
        4:       op = sa_pkg::OP_DRAINSYS;
        5:       op = OP_ST;
        default:
                if (op == sa_pkg::OP_LD || op == sa_pkg::OP_GEMM || op == sa_pkg::OP_DRAINSYS)
                        op = op ^ 4'h8;
        endcase
        w = '0;
        w[sa_pkg::OPCODE_LSB +: sa_pkg::OPCODE_W] = op;
        w[sa_pkg::BUF_ID_LSB +: sa_pkg::BUF_ID_W] = id;
        w[0 +: sa_pkg::MEM_LOC_W] = r[9:0];
        return w;
endfunction

function automatic bit is_load(input logic [sa_pkg::INST_W-1:0] w);
        logic [sa_pkg::BUF_ID_W-1:0] id;
        id = w[sa_pkg::BUF_ID_LSB +: sa_pkg::BUF_ID_W];
        return (w[sa_pkg::OPCODE_LSB +: sa_pkg::OPCODE_W] == sa_pkg::OP_LD) &&
               (id == sa_pkg::BUF_LEFT || id == sa_pkg::BUF_TOP);
endfunction

function automatic int hold_cycles(input logic [sa_pkg::INST_W-1:0] w);
        case (w[sa_pkg::OPCODE_LSB +: sa_pkg::OPCODE_W])
        sa_pkg::OP_GEMM:     return sa_pkg::GEMM_CYCLES;
        sa_pkg::OP_DRAINSYS: return sa_pkg::DRAIN_CYCLES;
        default:             return 0;
        endcase
endfunction

function automatic logic [sa_pkg::CTRL_W-1:0] hold_state(input logic [sa_pkg::INST_W-1:0] w);
        case (w[sa_pkg::OPCODE_LSB +: sa_pkg::OPCODE_W])
        sa_pkg::OP_GEMM:     return sa_pkg::CTRL_STEADY;
        sa_pkg::OP_DRAINSYS: return sa_pkg::CTRL_DRAIN;
        default:             return sa_pkg::CTRL_IDLE;
        endcase
endfunction

`endif

// File: tb/tb_inst_reader.sv
`timescale 1ns/1ps

module tb_inst_reader;

        logic                           clk = 1'b0;
        logic                           rst_n;
        logic                           i_inst_req;
        logic [sa_pkg::INST_W-1:0]      i_inst_word;
        logic                           o_inst_ack;
        logic                           i_store_we;
        logic [sa_pkg::MEM_LOC_W-1:0]   i_store_addr;
        logic [sa_pkg::DATA_W-1:0]      i_store_wdata;
        logic                           o_left_wr_en;
        logic                           o_top_wr_en;
        logic [sa_pkg::BUF_ADDR_W-1:0]  o_buf_wr_addr;
        logic [sa_pkg::ROW_W-1:0]       o_buf_wr_data;
        logic [sa_pkg::CTRL_W-1:0]      o_ctrl_state;

        int     cycles     = 0;
        int     checks     = 0;
        int     value_errs = 0;
        int     proto_errs = 0;
        bit     stuck      = 1'b0;

        `include "tb_model.svh"

        inst_reader_top DUT (
                .clk            (clk),
                .rst_n          (rst_n),
                .i_inst_req     (i_inst_req),
                .i_inst_word    (i_inst_word),
                .o_inst_ack     (o_inst_ack),
                .i_store_we     (i_store_we),
                .i_store_addr   (i_store_addr),
                .i_store_wdata  (i_store_wdata),
                .o_left_wr_en   (o_left_wr_en),
                .o_top_wr_en    (o_top_wr_en),
                .o_buf_wr_addr  (o_buf_wr_addr),
                .o_buf_wr_data  (o_buf_wr_data),
                .o_ctrl_state   (o_ctrl_state)
        );

        always #20 clk = ~clk;

        always @(posedge clk)
        begin
                cycles = cycles + 1;
                if (cycles > TIMEOUT_CYCLES)
                begin
                        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        task automatic check_write(input logic [sa_pkg::BUF_ADDR_W-1:0] exp_addr,
                                   input logic [sa_pkg::BUF_ADDR_W-1:0] act_addr,
                                   input logic [sa_pkg::ROW_W-1:0] exp_row,
                                   input logic [sa_pkg::ROW_W-1:0] act_row,
                                   input logic exp_top,
                                   input logic act_left,
                                   input logic act_top);
                checks++;
                if (act_top !== exp_top || act_left !== !exp_top)
                begin
                        proto_errs++;
                        $display("Row went to the wrong buffer with left enable %b and top enable %b",
                                 act_left, act_top);
                end
                if (act_addr !== exp_addr)
                begin
                        value_errs++;
                        $display("[FAIL] o_buf_wr_addr expected %h actual %h", exp_addr, act_addr);
                end
                if (act_row !== exp_row)
                begin
                        value_errs++;
                        $display("[FAIL] o_buf_wr_data expected %h actual %h", exp_row, act_row);
                end
        endtask

        task automatic check_state(input logic [sa_pkg::CTRL_W-1:0] exp_st,
                                   input logic [sa_pkg::CTRL_W-1:0] act_st);
                checks++;
                if (act_st !== exp_st)
                begin
                        value_errs++;
                        $display("[FAIL] o_ctrl_state expected %h actual %h", exp_st, act_st);
                end
        endtask

        // No ack, no write and no active state while nothing is in flight
        task automatic check_quiet();
                check_state(sa_pkg::CTRL_IDLE, o_ctrl_state);
                if (o_inst_ack)
                begin
                        proto_errs++;
                        $display("Ack is high with no request outstanding");
                end
                if (o_left_wr_en || o_top_wr_en)
                begin
                        proto_errs++;
                        $display("Buffer write with no instruction in flight");
                end
        endtask

        task automatic run_inst(input int n, input logic [sa_pkg::INST_W-1:0] w);
                int                             k;
                int                             wr_cnt;
                int                             n_hold;
                bit                             gap;
                bit                             load;
                logic                           exp_top;
                logic [sa_pkg::CTRL_W-1:0]      hold_code;
                logic [sa_pkg::CTRL_W-1:0]      exp_st;
                logic [sa_pkg::MEM_LOC_W-1:0]   base;
                load      = is_load(w);
                n_hold    = hold_cycles(w);
                hold_code = hold_state(w);
                exp_top   = (w[sa_pkg::BUF_ID_LSB +: sa_pkg::BUF_ID_W] == sa_pkg::BUF_TOP);
                base      = w[0 +: sa_pkg::MEM_LOC_W];
                k         = 0;
                wr_cnt    = 0;
                gap       = 1'b0;
                @(posedge clk);
                #1;
                i_inst_word = w;
                i_inst_req  = 1'b1;
                do
                begin
                        @(negedge clk);
                        if (o_left_wr_en || o_top_wr_en)
                        begin
                                if (!load || gap || wr_cnt >= sa_pkg::SKEW_STEPS)
                                begin
                                        proto_errs++;
                                        $display("Instruction %0d: extra buffer write", n);
                                end
                                else
                                begin
                                        check_write(sa_pkg::BUF_ADDR_W'(wr_cnt), o_buf_wr_addr,
                                                    skew_row(base, wr_cnt), o_buf_wr_data,
                                                    exp_top, o_left_wr_en, o_top_wr_en);
                                        wr_cnt++;
                                end
                        end
                        else if (wr_cnt > 0)
                                gap = 1'b1;
                        // Start pulse shows at k=1 and the hold state begins one cycle later
                        exp_st = (k >= 2 && k <= n_hold + 1) ? hold_code : sa_pkg::CTRL_IDLE;
                        check_state(exp_st, o_ctrl_state);
                        k++;
                        if (!o_inst_ack && k > ACK_LIMIT)
                        begin
                                proto_errs++;
                                $display("Instruction %0d: no ack within %0d cycles", n, ACK_LIMIT);
                                stuck = 1'b1;
                        end
                end
                while (!o_inst_ack && !stuck);
                if (stuck)
                        return;
                if (wr_cnt != (load ? sa_pkg::SKEW_STEPS : 0))
                begin
                        proto_errs++;
                        $display("Instruction %0d: %0d buffer writes, expected %0d", n, wr_cnt,
                                 load ? sa_pkg::SKEW_STEPS : 0);
                end
                if (n_hold > 0 && k <= n_hold + 3)
                begin
                        proto_errs++;
                        $display("Instruction %0d: ack came before the array returned to idle", n);
                end
                @(posedge clk);
                #1;
                i_inst_req = 1'b0;
                // Ack falls the cycle after the low request is seen
                repeat (2) @(negedge clk);
                check_state(sa_pkg::CTRL_IDLE, o_ctrl_state);
                if (o_inst_ack)
                begin
                        proto_errs++;
                        $display("Instruction %0d: ack still high after the request dropped", n);
                end
        endtask

        initial
        begin
                int             kind;
                logic [31:0]    r;
                rst_n         = 1'b0;
                i_inst_req    = 1'b0;
                i_inst_word   = '0;
                i_store_we    = 1'b0;
                i_store_addr  = '0;
                i_store_wdata = '0;
                repeat (2) @(posedge clk);
                #1;
                rst_n = 1'b1;
                // Fill the whole store and mirror it in the image
                for (int a = 0; a < sa_pkg::STORE_DEPTH; a++)
                begin
                        r = next_rand();
                        i_store_we    = 1'b1;
                        i_store_addr  = sa_pkg::MEM_LOC_W'(a);
                        i_store_wdata = r[7:0];
                        image[i_store_addr] = r[7:0];
                        @(negedge clk);
                        check_quiet();
                        @(posedge clk);
                        #1;
                end
                i_store_we = 1'b0;
                for (int n = 0; n < NUM_INSTS && !stuck; n++)
                begin
                        r = next_rand();
                        kind = int'(r[31:16] % 16'd7);
                        run_inst(n, make_inst(kind, r));
                end
                repeat (4)
                begin
                        @(negedge clk);
                        check_quiet();
                end
                $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                         checks, value_errs, proto_errs);
                if (value_errs + proto_errs == 0)
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

// File: design/inst_reader_top.sv
`timescale 1ns/1ps

module inst_reader_top (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            i_inst_req,
        input  logic [sa_pkg::INST_W-1:0]       i_inst_word,
        output logic                            o_inst_ack,
        input  logic                            i_store_we,
        input  logic [sa_pkg::MEM_LOC_W-1:0]    i_store_addr,
        input  logic [sa_pkg::DATA_W-1:0]       i_store_wdata,
        output logic                            o_left_wr_en,
        output logic                            o_top_wr_en,
        output logic [sa_pkg::BUF_ADDR_W-1:0]   o_buf_wr_addr,
        output logic [sa_pkg::ROW_W-1:0]        o_buf_wr_data,
        output logic [sa_pkg::CTRL_W-1:0]       o_ctrl_state
);

        logic                                           start;
        logic                                           done;
        logic [sa_pkg::OPCODE_W-1:0]                    opcode;
        logic [sa_pkg::BUF_ID_W-1:0]                    buf_id;
        logic [sa_pkg::MEM_LOC_W-1:0]                   mem_loc;
        logic                                           load_start;
        logic                                           load_top;
        logic [sa_pkg::MEM_LOC_W-1:0]                   load_base;
        logic                                           load_done;
        logic [sa_pkg::ARRAY_DIM*sa_pkg::MEM_LOC_W-1:0] lane_addr;
        logic [sa_pkg::ROW_W-1:0]                       lane_data;

        inst_intake u_intake (
                .clk            (clk),
                .rst_n          (rst_n),
                .i_inst_req     (i_inst_req),
                .i_inst_word    (i_inst_word),
                .o_inst_ack     (o_inst_ack),
                .o_start        (start),
                .o_opcode       (opcode),
                .o_buf_id       (buf_id),
                .o_mem_loc      (mem_loc),
                .i_done         (done)
        );

        inst_sequencer u_sequencer (
                .clk            (clk),
                .rst_n          (rst_n),
                .i_start        (start),
                .i_opcode       (opcode),
                .i_buf_id       (buf_id),
                .i_mem_loc      (mem_loc),
                .o_done         (done),
                .o_ctrl_state   (o_ctrl_state),
                .o_load_start   (load_start),
                .o_load_top     (load_top),
                .o_load_base    (load_base),
                .i_load_done    (load_done)
        );

        skew_loader u_loader (
                .clk            (clk),
                .rst_n          (rst_n),
                .i_load_start   (load_start),
                .i_load_top     (load_top),
                .i_load_base    (load_base),
                .o_load_done    (load_done),
                .o_lane_addr    (lane_addr),
                .i_lane_data    (lane_data),
                .o_left_wr_en   (o_left_wr_en),
                .o_top_wr_en    (o_top_wr_en),
                .o_buf_wr_addr  (o_buf_wr_addr),
                .o_buf_wr_data  (o_buf_wr_data)
        );

        operand_store u_store (
                .clk            (clk),
                .i_store_we     (i_store_we),
                .i_store_addr   (i_store_addr),
                .i_store_wdata  (i_store_wdata),
                .i_lane_addr    (lane_addr),
                .o_lane_data    (lane_data)
        );

endmodule

// File: design/skew_loader.sv
`timescale 1ns/1ps

module skew_loader (
        input  logic                                            clk,
        input  logic                                            rst_n,
        input  logic                                            i_load_start,
        input  logic                                            i_load_top,
        input  logic [sa_pkg::MEM_LOC_W-1:0]                    i_load_base,
        output logic                                            o_load_done,
        output logic [sa_pkg::ARRAY_DIM*sa_pkg::MEM_LOC_W-1:0]  o_lane_addr,
        input  logic [sa_pkg::ROW_W-1:0]                        i_lane_data,
        output logic                                            o_left_wr_en,
        output logic                                            o_top_wr_en,
        output logic [sa_pkg::BUF_ADDR_W-1:0]                   o_buf_wr_addr,
        output logic [sa_pkg::ROW_W-1:0]                        o_buf_wr_data
);

        logic [sa_pkg::MEM_LOC_W-1:0]   base;
        logic [sa_pkg::MEM_LOC_W-1:0]   cur_base;
        logic [sa_pkg::BUF_ADDR_W-1:0]  cur_step;
        logic [sa_pkg::ROW_W-1:0]       row;
        logic                           wr_any;
        logic                           last_step;
        logic                           walking;

        // The write address doubles as the step counter
        assign wr_any    = o_left_wr_en | o_top_wr_en;
        assign last_step = (o_buf_wr_addr == sa_pkg::BUF_ADDR_W'(sa_pkg::SKEW_STEPS - 1));
        assign walking   = wr_any && !last_step;
        assign cur_step  = walking ? o_buf_wr_addr + 1'b1 : '0;
        assign cur_base  = walking ? base : i_load_base;

        // Lane j reads diagonal element (s-j, j) of the tile
        always_comb
        begin
                for (int j = 0; j < sa_pkg::ARRAY_DIM; j++)
                begin
                        int diag;
                        diag = int'(cur_step) - j;
                        o_lane_addr[j*sa_pkg::MEM_LOC_W +: sa_pkg::MEM_LOC_W] =
                                sa_pkg::MEM_LOC_W'(int'(cur_base) + diag * sa_pkg::ARRAY_DIM + j);
                        if (diag >= 0 && diag < sa_pkg::ARRAY_DIM)
                                row[j*sa_pkg::DATA_W +: sa_pkg::DATA_W] =
                                        i_lane_data[j*sa_pkg::DATA_W +: sa_pkg::DATA_W];
                        else
                                row[j*sa_pkg::DATA_W +: sa_pkg::DATA_W] = '0;
                end
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        o_left_wr_en  <= 1'b0;
                        o_top_wr_en   <= 1'b0;
                        o_buf_wr_addr <= '0;
                        o_load_done   <= 1'b0;
                end
                else
                begin
                        o_load_done <= wr_any && last_step;
                        if (i_load_start)
                        begin
                                o_left_wr_en  <= !i_load_top;
                                o_top_wr_en   <= i_load_top;
                                o_buf_wr_addr <= '0;
                        end
                        else if (walking)
                        begin
                                o_buf_wr_addr <= cur_step;
                        end
                        else
                        begin
                                o_left_wr_en <= 1'b0;
                                o_top_wr_en  <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk)
        begin
                if (i_load_start)
                        base <= i_load_base;
                if (i_load_start || walking)
                        o_buf_wr_data <= row;
        end

        a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
                i_load_start |-> !wr_any)
                else $error("load started while a diagonal walk is in progress");

endmodule

// File: design/inst_sequencer.sv
`timescale 1ns/1ps

module inst_sequencer (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            i_start,
        input  logic [sa_pkg::OPCODE_W-1:0]     i_opcode,
        input  logic [sa_pkg::BUF_ID_W-1:0]     i_buf_id,
        input  logic [sa_pkg::MEM_LOC_W-1:0]    i_mem_loc,
        output logic                            o_done,
        output logic [sa_pkg::CTRL_W-1:0]       o_ctrl_state,
        output logic                            o_load_start,
        output logic                            o_load_top,
        output logic [sa_pkg::MEM_LOC_W-1:0]    o_load_base,
        input  logic                            i_load_done
);

        logic [sa_pkg::CNT_W-1:0]       cycle_cnt;
        logic                           loading;
        logic                           ld_valid;

        // LD only targets the left or top buffer
        assign ld_valid = (i_opcode == sa_pkg::OP_LD) &&
                          ((i_buf_id == sa_pkg::BUF_LEFT) || (i_buf_id == sa_pkg::BUF_TOP));

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        o_done       <= 1'b0;
                        o_load_start <= 1'b0;
                        o_ctrl_state <= sa_pkg::CTRL_IDLE;
                        cycle_cnt    <= '0;
                        loading      <= 1'b0;
                end
                else
                begin
                        o_done       <= 1'b0;
                        o_load_start <= 1'b0;
                        if (i_start)
                        begin
                                if (i_opcode == sa_pkg::OP_GEMM)
                                begin
                                        o_ctrl_state <= sa_pkg::CTRL_STEADY;
                                        cycle_cnt    <= sa_pkg::CNT_W'(sa_pkg::GEMM_CYCLES - 1);
                                end
                                else if (i_opcode == sa_pkg::OP_DRAINSYS)
                                begin
                                        o_ctrl_state <= sa_pkg::CTRL_DRAIN;
                                        cycle_cnt    <= sa_pkg::CNT_W'(sa_pkg::DRAIN_CYCLES - 1);
                                end
                                else if (ld_valid)
                                begin
                                        o_load_start <= 1'b1;
                                        loading      <= 1'b1;
                                end
                                else
                                begin
                                        o_done <= 1'b1;
                                end
                        end
                        else if (o_ctrl_state != sa_pkg::CTRL_IDLE)
                        begin
                                if (cycle_cnt == '0)
                                begin
                                        o_ctrl_state <= sa_pkg::CTRL_IDLE;
                                        o_done       <= 1'b1;
                                end
                                else
                                begin
                                        cycle_cnt <= cycle_cnt - 1'b1;
                                end
                        end
                        else if (loading && i_load_done)
                        begin
                                loading <= 1'b0;
                                o_done  <= 1'b1;
                        end
                end
        end

        // Load target and base latched with the start pulse
        always_ff @(posedge clk)
        begin
                if (i_start && ld_valid)
                begin
                        o_load_top  <= (i_buf_id == sa_pkg::BUF_TOP);
                        o_load_base <= i_mem_loc;
                end
        end

        a_idle_while_loading: assert property (@(posedge clk) disable iff (!rst_n)
                loading |-> (o_ctrl_state == sa_pkg::CTRL_IDLE))
                else $error("array control not idle during a buffer load");

endmodule

// File: design/operand_store.sv
`timescale 1ns/1ps

module operand_store (
        input  logic                                            clk,
        input  logic                                            i_store_we,
        input  logic [sa_pkg::MEM_LOC_W-1:0]                    i_store_addr,
        input  logic [sa_pkg::DATA_W-1:0]                       i_store_wdata,
        input  logic [sa_pkg::ARRAY_DIM*sa_pkg::MEM_LOC_W-1:0]  i_lane_addr,
        output logic [sa_pkg::ROW_W-1:0]                        o_lane_data
);

        logic [sa_pkg::DATA_W-1:0] mem [sa_pkg::STORE_DEPTH];

        // Host write port
        always_ff @(posedge clk)
        begin
                if (i_store_we)
                        mem[i_store_addr] <= i_store_wdata;
        end

        // All lanes are read in the same cycle
        always_comb
        begin
                for (int j = 0; j < sa_pkg::ARRAY_DIM; j++)
                begin
                        o_lane_data[j*sa_pkg::DATA_W +: sa_pkg::DATA_W] =
                                mem[i_lane_addr[j*sa_pkg::MEM_LOC_W +: sa_pkg::MEM_LOC_W]];
                end
        end

endmodule

// File: design/inst_intake.sv
`timescale 1ns/1ps

module inst_intake (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            i_inst_req,
        input  logic [sa_pkg::INST_W-1:0]       i_inst_word,
        output logic                            o_inst_ack,
        output logic                            o_start,
        output logic [sa_pkg::OPCODE_W-1:0]     o_opcode,
        output logic [sa_pkg::BUF_ID_W-1:0]     o_buf_id,
        output logic [sa_pkg::MEM_LOC_W-1:0]    o_mem_loc,
        input  logic                            i_done
);

        // Waiting is !busy && !o_inst_ack
        logic                           busy;
        logic [sa_pkg::INST_W-1:0]      inst_word;

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        busy       <= 1'b0;
                        o_start    <= 1'b0;
                        o_inst_ack <= 1'b0;
                end
                else
                begin
                        o_start <= 1'b0;
                        if (!busy && !o_inst_ack && i_inst_req)
                        begin
                                busy    <= 1'b1;
                                o_start <= 1'b1;
                        end
                        else if (busy && i_done)
                        begin
                                busy       <= 1'b0;
                                o_inst_ack <= 1'b1;
                        end
                        else if (o_inst_ack && !i_inst_req)
                        begin
                                o_inst_ack <= 1'b0;
                        end
                end
        end

        // Word held for the whole instruction
        always_ff @(posedge clk)
        begin
                if (!busy && !o_inst_ack && i_inst_req)
                        inst_word <= i_inst_word;
        end

        assign o_opcode  = inst_word[sa_pkg::OPCODE_LSB +: sa_pkg::OPCODE_W];
        assign o_buf_id  = inst_word[sa_pkg::BUF_ID_LSB +: sa_pkg::BUF_ID_W];
        assign o_mem_loc = inst_word[0 +: sa_pkg::MEM_LOC_W];

        a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
                $rose(o_inst_ack) |-> i_inst_req)
                else $error("ack raised without a pending request");

endmodule

// File: design/sa_pkg.sv
package sa_pkg;

        // Array geometry and operand widths
        localparam int ARRAY_DIM   = 8;
        localparam int DATA_W      = 8;
        localparam int ROW_W       = ARRAY_DIM * DATA_W;

        // Instruction word layout
        localparam int INST_W      = 16;
        localparam int OPCODE_W    = 4;
        localparam int BUF_ID_W    = 2;
        localparam int MEM_LOC_W   = 10;
        localparam int OPCODE_LSB  = 12;
        localparam int BUF_ID_LSB  = 10;

        // Storage
        localparam int STORE_DEPTH = 1024;
        localparam int BUF_ADDR_W  = 10;

        // Any opcode not listed here is a no-op
        localparam logic [OPCODE_W-1:0] OP_LD       = 'd2;
        localparam logic [OPCODE_W-1:0] OP_GEMM     = 'd4;
        localparam logic [OPCODE_W-1:0] OP_DRAINSYS = 'd5;

        localparam logic [BUF_ID_W-1:0] BUF_LEFT    = 'd0;
        localparam logic [BUF_ID_W-1:0] BUF_TOP     = 'd1;

        // Array control state
        localparam int CTRL_W = 4;
        localparam logic [CTRL_W-1:0] CTRL_IDLE   = 'd0;
        localparam logic [CTRL_W-1:0] CTRL_STEADY = 'd1;
        localparam logic [CTRL_W-1:0] CTRL_DRAIN  = 'd3;

        // Cycle counts
        localparam int GEMM_CYCLES  = 2 * ARRAY_DIM + ARRAY_DIM;
        localparam int DRAIN_CYCLES = 2 * ARRAY_DIM;
        localparam int SKEW_STEPS   = 2 * ARRAY_DIM - 1;

        // Counter width for the longer of the two hold counts
        localparam int CNT_W = $clog2(GEMM_CYCLES);

endpackage
